/* verilog.f */
+incdir+verif
rtl/snooper_pkg.sv
rtl/snoop_cfg_regs.sv
rtl/trace_filter.sv
rtl/trace_ring_buffer.sv
rtl/trace_readout.sv
rtl/snooper.sv
verif/snooper_tb.sv

/* Makefile */
# Verilator build and run of the snooper testbench

VERILATOR ?= verilator
TOP       ?= snooper_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/snooper_tb_model.svh */
// Reference rules and expected-buffer model, included inside the snooper testbench module
`ifndef SNOOPER_TB_MODEL_SVH
`define SNOOPER_TB_MODEL_SVH

// Expected buffer contents, oldest entry first
trace_entry_t model_q[$];

// Recording rule: valid, enabled, legal mode with its mask bit, inside the window if used
function automatic logic filter_pass(cfg_t c, trace_t ev);
   logic in_window;
   in_window = (ev.pc_src >= c.range_lo) && (ev.pc_src <= c.range_hi);
   return ev.valid && c.snoop_en && (ev.priv != 2'd2) && c.priv_mask[ev.priv] &&
          (!c.range_en || in_window);
endfunction

// Trigger rule, independent of snoop_en
function automatic logic trigger_match(cfg_t c, trace_t ev);
   return ev.valid && c.trig_en && (ev.pc_dst == c.trig_pc);
endfunction

function automatic logic irq_expected(cfg_t c, int unsigned fill);
   return (c.watermark != 16'd0) && (fill >= 32'(c.watermark));
endfunction

function automatic cfg_t cfg_after_write(cfg_t c, cfg_addr_t addr, cfg_word_t data);
   cfg_t n;
   n = c;
   case (addr)
      CFG_CTRL: begin
         n.snoop_en  = data[0];
         n.range_en  = data[1];
         n.trig_en   = data[2];
         n.priv_mask = data[7:4];
      end
      CFG_RANGE_LO:  n.range_lo = data;
      CFG_RANGE_HI:  n.range_hi = data;
      CFG_TRIG_PC:   n.trig_pc = data;
      CFG_WATERMARK: n.watermark = data[15:0];
      default:       n = c;
   endcase
   return n;
endfunction

function automatic trace_entry_t to_entry(trace_t ev);
   trace_entry_t e;
   e.priv     = ev.priv;
   e.ctr_type = ev.ctr_type;
   e.pc_src   = ev.pc_src;
   e.pc_dst   = ev.pc_dst;
   return e;
endfunction

// A full buffer loses its oldest entry
function automatic void model_store(trace_entry_t e);
   if (model_q.size() == DEPTH) begin
      model_q.delete(0);
   end
   model_q.push_back(e);
endfunction

`endif

/* verif/snooper_tb.sv */
// Self-checking testbench for the trace snooper, built from verilog.f with snooper_tb as top
`timescale 1ns/1ns
`default_nettype none

module snooper_tb
   import snooper_pkg::*;
();

   localparam int DEPTH      = 8;
   localparam int CLK_PERIOD = 40;
   localparam int DRIVE_DLY  = 2;
   localparam int RD_TIMEOUT = 20;
   localparam int SEED       = 63096;

   logic         clk_i;
   logic         arst_n_i;
   trace_t       trace_i;
   logic         cfg_we_i;
   cfg_addr_t    cfg_addr_i;
   cfg_word_t    cfg_wdata_i;
   logic         sw_rd_req_i;
   logic         sw_rd_valid_o;
   logic         sw_rd_empty_o;
   trace_entry_t sw_rd_entry_o;
   logic         watermark_irq_o;
   logic         trigger_o;

   // Model state and expected outputs for the current cycle
   cfg_t         model_cfg;
   trace_t       pend_ev;
   logic         model_hit;
   logic         exp_rd_valid;
   logic         exp_rd_empty;
   trace_entry_t exp_entry;
   logic         exp_trig;
   logic         exp_irq;

   int           errors;
   int           checks;
   int           trig_pulses;
   int           trig_before;
   int           n_reads;
   int unsigned  rnd;
   logic         rd_empty;
   trace_entry_t rd_entry;

   `include "snooper_tb_model.svh"

   snooper #(
      .DEPTH ( DEPTH )
   ) snooper_i (
      .clk_i           ( clk_i           ),
      .arst_n_i        ( arst_n_i        ),
      .trace_i         ( trace_i         ),
      .cfg_we_i        ( cfg_we_i        ),
      .cfg_addr_i      ( cfg_addr_i      ),
      .cfg_wdata_i     ( cfg_wdata_i     ),
      .sw_rd_req_i     ( sw_rd_req_i     ),
      .sw_rd_valid_o   ( sw_rd_valid_o   ),
      .sw_rd_empty_o   ( sw_rd_empty_o   ),
      .sw_rd_entry_o   ( sw_rd_entry_o   ),
      .watermark_irq_o ( watermark_irq_o ),
      .trigger_o       ( trigger_o       )
   );

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   //////////////////////////////////////////////////////////////////////
   // Reference model stepped on every rising edge
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         model_cfg    = '0;
         pend_ev      = '0;
         exp_rd_valid = 1'b0;
         exp_rd_empty = 1'b0;
         exp_entry    = '0;
         exp_trig     = 1'b0;
         exp_irq      = 1'b0;
         model_q.delete();
      end else begin
         model_hit    = trigger_match(model_cfg, pend_ev);
         exp_irq      = irq_expected(model_cfg, model_q.size());
         exp_rd_valid = sw_rd_req_i;
         exp_rd_empty = sw_rd_req_i && (model_q.size() == 0);
         exp_entry    = '0;
         // Pop before store keeps order when both hit a full buffer
         if (sw_rd_req_i && (model_q.size() != 0)) begin
            exp_entry = model_q.pop_front();
         end
         if (filter_pass(model_cfg, pend_ev)) begin
            model_store(to_entry(pend_ev));
         end
         exp_trig = model_hit;
         if (cfg_we_i) begin
            model_cfg = cfg_after_write(model_cfg, cfg_addr_i, cfg_wdata_i);
         end
         // Hardware clear wins over a write at the same edge
         if (model_hit) begin
            model_cfg.snoop_en = 1'b0;
            model_cfg.trig_en  = 1'b0;
         end
         pend_ev = trace_i;
      end
   end

   task automatic report_mismatch(input string name, input logic [69:0] got,
                                  input logic [69:0] exp);
      errors++;
      $display("ERROR: %s = %0h, expected %0h", name, got, exp);
   endtask

   // Outputs compared mid-cycle away from both edges
   always @(negedge clk_i) begin
      if (arst_n_i) begin
         checks++;
         if (trigger_o) begin
            trig_pulses++;
         end
         assert (sw_rd_valid_o === exp_rd_valid)
            else report_mismatch("sw_rd_valid_o", 70'(sw_rd_valid_o), 70'(exp_rd_valid));
         if (exp_rd_valid) begin
            assert (sw_rd_empty_o === exp_rd_empty)
               else report_mismatch("sw_rd_empty_o", 70'(sw_rd_empty_o), 70'(exp_rd_empty));
            assert (sw_rd_entry_o === exp_entry)
               else report_mismatch("sw_rd_entry_o", sw_rd_entry_o, exp_entry);
         end
         assert (trigger_o === exp_trig)
            else report_mismatch("trigger_o", 70'(trigger_o), 70'(exp_trig));
         assert (watermark_irq_o === exp_irq)
            else report_mismatch("watermark_irq_o", 70'(watermark_irq_o), 70'(exp_irq));
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge clk_i);
      #DRIVE_DLY;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) next_cycle();
   endtask

   task automatic write_cfg(input cfg_addr_t addr, input cfg_word_t data);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      next_cycle();
      cfg_we_i = 1'b0;
   endtask

   task automatic send_event(input logic [1:0] priv, input pc_t src, input pc_t dst);
      trace_i.valid    = 1'b1;
      trace_i.priv     = priv_t'(priv);
      trace_i.ctr_type = 4'h2;
      trace_i.pc_src   = src;
      trace_i.pc_dst   = dst;
      next_cycle();
      trace_i.valid = 1'b0;
   endtask

   task automatic read_entry(output logic empty, output trace_entry_t entry);
      int waited;
      waited      = 0;
      sw_rd_req_i = 1'b1;
      next_cycle();
      sw_rd_req_i = 1'b0;
      while (!sw_rd_valid_o && (waited < RD_TIMEOUT)) begin
         next_cycle();
         waited++;
      end
      if (!sw_rd_valid_o) begin
         errors++;
         $display("Timed out waiting for a read result");
      end
      empty = sw_rd_empty_o;
      entry = sw_rd_entry_o;
   endtask

   // Reads until an empty reply and counts that reply too
   task automatic drain_buffer(output int reads);
      logic         empty;
      trace_entry_t entry;
      reads = 0;
      empty = 1'b0;
      idle_cycles(3);
      while (!empty && (reads <= DEPTH + 1)) begin
         read_entry(empty, entry);
         reads++;
      end
      assert (empty) else begin
         errors++;
         $display("Buffer still holds entries after draining");
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      errors      = 0;
      checks      = 0;
      trig_pulses = 0;
      arst_n_i    = 1'b0;
      trace_i     = '0;
      cfg_we_i    = 1'b0;
      cfg_addr_i  = CFG_CTRL;
      cfg_wdata_i = '0;
      sw_rd_req_i = 1'b0;
      rnd         = $urandom(SEED);
      repeat (16) @(posedge clk_i);
      #DRIVE_DLY;
      arst_n_i = 1'b1;

      // Empty read straight after reset
      read_entry(rd_empty, rd_entry);
      assert (rd_empty && (rd_entry == '0)) else begin
         errors++;
         $display("Read after reset did not return an empty reply");
      end

      // Random events, random mode masks, window off and on
      for (int round = 0; round < 4; round++) begin
         rnd = $urandom;
         write_cfg(CFG_RANGE_LO, 32'h0000_1000);
         write_cfg(CFG_RANGE_HI, 32'h0000_13FF);
         write_cfg(CFG_CTRL, {24'd0, rnd[3:0], 2'b00, round[0], 1'b1});
         for (int i = 0; i < 24; i++) begin
            rnd = $urandom;
            trace_i.valid    = (rnd[1:0] != 2'd0);
            trace_i.priv     = priv_t'(rnd[3:2]);
            trace_i.ctr_type = rnd[7:4];
            // Source PCs straddle both window bounds
            trace_i.pc_src   = 32'h0000_0800 + {20'd0, rnd[19:8]};
            trace_i.pc_dst   = $urandom;
            sw_rd_req_i      = (rnd[21:20] == 2'd0);
            next_cycle();
         end
         trace_i.valid = 1'b0;
         sw_rd_req_i   = 1'b0;
         drain_buffer(n_reads);
      end

      // Overflow keeps the last DEPTH entries
      write_cfg(CFG_CTRL, 32'h0000_00F1);
      for (int i = 0; i < 12; i++) begin
         send_event(2'd3, 32'h100 + 32'(4 * i), 32'h8000_0000 + 32'(i));
      end
      idle_cycles(3);
      for (int i = 0; i < DEPTH; i++) begin
         read_entry(rd_empty, rd_entry);
         assert (!rd_empty && (rd_entry.pc_src == 32'h100 + 32'(4 * (i + 4))))
            else report_mismatch("sw_rd_entry_o.pc_src", 70'(rd_entry.pc_src),
                                 70'(32'h100 + 32'(4 * (i + 4))));
      end
      read_entry(rd_empty, rd_entry);
      assert (rd_empty) else begin
         errors++;
         $display("Drained buffer did not return an empty reply");
      end

      // Watermark at 5 and then disabled
      write_cfg(CFG_WATERMARK, 32'd5);
      for (int i = 0; i < DEPTH; i++) begin
         send_event(2'd0, 32'h200 + 32'(i), 32'h300);
         idle_cycles(3);
      end
      write_cfg(CFG_WATERMARK, 32'd0);
      idle_cycles(2);
      drain_buffer(n_reads);

      // Trigger stops recording and disarms itself
      write_cfg(CFG_TRIG_PC, 32'hDEAD_BEE0);
      write_cfg(CFG_CTRL, 32'h0000_00F5);
      trig_before = trig_pulses;
      send_event(2'd3, 32'h400, 32'h404);
      send_event(2'd3, 32'h408, 32'hDEAD_BEE0);
      send_event(2'd3, 32'h40C, 32'h410);
      idle_cycles(3);
      send_event(2'd3, 32'h410, 32'hDEAD_BEE0);
      idle_cycles(3);
      assert (trig_pulses == trig_before + 1) else begin
         errors++;
         $display("Expected exactly one trigger pulse, saw %0d", trig_pulses - trig_before);
      end
      drain_buffer(n_reads);
      assert (n_reads == 3) else begin
         errors++;
         $display("Recording did not stop after the trigger");
      end
      write_cfg(CFG_CTRL, 32'h0000_00F1);
      send_event(2'd1, 32'h500, 32'hDEAD_BEE0);
      drain_buffer(n_reads);
      assert (n_reads == 2) else begin
         errors++;
         $display("Recording did not resume after snoop_en was rewritten");
      end

      idle_cycles(2);
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* rtl/snooper.sv */
// Top level of the control-flow trace snooper, connecting configuration, filter, buffer and readout
`timescale 1ns/1ns
`default_nettype none

module snooper
   import snooper_pkg::*;
#(
   parameter int unsigned DEPTH = 16
) (
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  trace_t       trace_i,
   input  logic         cfg_we_i,
   input  cfg_addr_t    cfg_addr_i,
   input  cfg_word_t    cfg_wdata_i,
   input  logic         sw_rd_req_i,
   output logic         sw_rd_valid_o,
   output logic         sw_rd_empty_o,
   output trace_entry_t sw_rd_entry_o,
   output logic         watermark_irq_o,
   output logic         trigger_o
);

   localparam int unsigned CNT_W = $clog2(DEPTH) + 1;

   cfg_t             cfg;
   logic             wr_en;
   trace_entry_t     wr_entry;
   logic             rd_en;
   trace_entry_t     rd_entry;
   logic             rd_valid;
   logic [CNT_W-1:0] count;

   //////////////////////////////////////////////////////////////////////
   // Configuration
   //////////////////////////////////////////////////////////////////////

   snoop_cfg_regs u_cfg_regs (
      .clk_i       ( clk_i       ),
      .arst_n_i    ( arst_n_i    ),
      .cfg_we_i    ( cfg_we_i    ),
      .cfg_addr_i  ( cfg_addr_i  ),
      .cfg_wdata_i ( cfg_wdata_i ),
      .trigger_i   ( trigger_o   ),
      .cfg_o       ( cfg         )
   );

   //////////////////////////////////////////////////////////////////////
   // Producer, buffer and consumer
   //////////////////////////////////////////////////////////////////////

   trace_filter u_trace_filter (
      .clk_i      ( clk_i     ),
      .arst_n_i   ( arst_n_i  ),
      .trace_i    ( trace_i   ),
      .cfg_i      ( cfg       ),
      .wr_en_o    ( wr_en     ),
      .wr_entry_o ( wr_entry  ),
      .trigger_o  ( trigger_o )
   );

   trace_ring_buffer #(
      .DEPTH ( DEPTH )
   ) u_ring_buffer (
      .clk_i      ( clk_i    ),
      .arst_n_i   ( arst_n_i ),
      .wr_en_i    ( wr_en    ),
      .wr_entry_i ( wr_entry ),
      .rd_en_i    ( rd_en    ),
      .rd_entry_o ( rd_entry ),
      .rd_valid_o ( rd_valid ),
      .count_o    ( count    )
   );

   trace_readout #(
      .DEPTH ( DEPTH )
   ) u_readout (
      .clk_i           ( clk_i           ),
      .arst_n_i        ( arst_n_i        ),
      .sw_rd_req_i     ( sw_rd_req_i     ),
      .cfg_i           ( cfg             ),
      .count_i         ( count           ),
      .rd_entry_i      ( rd_entry        ),
      .rd_valid_i      ( rd_valid        ),
      .rd_en_o         ( rd_en           ),
      .sw_rd_valid_o   ( sw_rd_valid_o   ),
      .sw_rd_empty_o   ( sw_rd_empty_o   ),
      .sw_rd_entry_o   ( sw_rd_entry_o   ),
      .watermark_irq_o ( watermark_irq_o )
   );

endmodule

`default_nettype wire

/* rtl/trace_readout.sv */
// Consumer stage: turns software read strobes into pops or empty replies, raises watermark interrupt
`timescale 1ns/1ns
`default_nettype none

module trace_readout
   import snooper_pkg::*;
#(
   parameter int unsigned DEPTH = 16
) (
   input  logic                   clk_i,
   input  logic                   arst_n_i,
   input  logic                   sw_rd_req_i,
   input  cfg_t                   cfg_i,
   input  logic [$clog2(DEPTH):0] count_i,
   input  trace_entry_t           rd_entry_i,
   input  logic                   rd_valid_i,
   output logic                   rd_en_o,
   output logic                   sw_rd_valid_o,
   output logic                   sw_rd_empty_o,
   output trace_entry_t           sw_rd_entry_o,
   output logic                   watermark_irq_o
);

   logic       empty_q;
   logic       irq_q;
   watermark_t level;

   //////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////

   // Pop only when something is stored, otherwise answer empty
   assign rd_en_o = sw_rd_req_i && (count_i != '0);

   assign level = watermark_t'(count_i);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         empty_q <= 1'b0;
         irq_q   <= 1'b0;
      end else begin
         empty_q <= sw_rd_req_i && (count_i == '0);
         irq_q   <= (cfg_i.watermark != '0) && (level >= cfg_i.watermark);
      end
   end

   // Buffer data and empty reply land in the same cycle slot
   assign sw_rd_valid_o   = rd_valid_i || empty_q;
   assign sw_rd_empty_o   = empty_q;
   assign sw_rd_entry_o   = rd_valid_i ? rd_entry_i : '0;
   assign watermark_irq_o = irq_q;

   // Each result answers exactly one request made an edge earlier
   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      sw_rd_valid_o |-> $past(sw_rd_req_i) && !(rd_valid_i && empty_q))
      else $error("Read result without a matching request");

endmodule

`default_nettype wire

/* rtl/trace_ring_buffer.sv */
// Circular trace buffer that overwrites its oldest entry when full; pop data returns one cycle later
`timescale 1ns/1ns
`default_nettype none

module trace_ring_buffer
   import snooper_pkg::*;
#(
   parameter int unsigned DEPTH = 16
) (
   input  logic                       clk_i,
   input  logic                       arst_n_i,
   input  logic                       wr_en_i,
   input  trace_entry_t               wr_entry_i,
   input  logic                       rd_en_i,
   output trace_entry_t               rd_entry_o,
   output logic                       rd_valid_o,
   output logic [$clog2(DEPTH):0]     count_o
);

   localparam int unsigned PTR_W = $clog2(DEPTH);
   localparam int unsigned CNT_W = PTR_W + 1;

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] count_t;

   if ((DEPTH < 4) || ((DEPTH & (DEPTH - 1)) != 0)) begin : g_depth_check
      $error("DEPTH must be a power of two of at least 4");
   end

   //////////////////////////////////////////////////////////////////////
   // Storage and pointers
   //////////////////////////////////////////////////////////////////////

   trace_entry_t mem [DEPTH];
   ptr_t         wr_ptr_q;
   ptr_t         rd_ptr_q;
   count_t       count_q;
   logic         full;
   logic         rd_valid_q;

   assign full = (count_q == count_t'(DEPTH));

   always_ff @(posedge clk_i) begin
      if (wr_en_i) begin
         mem[wr_ptr_q] <= wr_entry_i;
      end
      if (rd_en_i) begin
         rd_entry_o <= mem[rd_ptr_q];
      end
   end

   // On a full buffer the write slot is the oldest one, so the read pointer
   // moves past it.  With a pop at the same edge the popped entry leaves and
   // the new one takes its place as the newest, order is preserved
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= rd_en_i;
         if (wr_en_i) begin
            wr_ptr_q <= wr_ptr_q + ptr_t'(1);
         end
         if (rd_en_i || (wr_en_i && full)) begin
            rd_ptr_q <= rd_ptr_q + ptr_t'(1);
         end
         case ({wr_en_i, rd_en_i})
            2'b10:   count_q <= full ? count_q : count_q + count_t'(1);
            2'b01:   count_q <= count_q - count_t'(1);
            default: count_q <= count_q;
         endcase
      end
   end

   assign rd_valid_o = rd_valid_q;
   assign count_o    = count_q;

   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      count_o <= count_t'(DEPTH))
      else $error("Fill count above DEPTH");

   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_en_i |-> (count_o != '0))
      else $error("Pop from an empty buffer");

endmodule

`default_nettype wire

/* rtl/trace_filter.sv */
// Producer stage: registers each core event, filters it by privilege and PC window, detects trigger
`timescale 1ns/1ns
`default_nettype none

module trace_filter
   import snooper_pkg::*;
(
   input  logic         clk_i,
   input  logic         arst_n_i,
   input  trace_t       trace_i,
   input  cfg_t         cfg_i,
   output logic         wr_en_o,
   output trace_entry_t wr_entry_o,
   output logic         trigger_o
);

   //////////////////////////////////////////////////////////////////////
   // Input register
   //////////////////////////////////////////////////////////////////////

   logic         valid_q;
   trace_entry_t entry_q;
   logic         priv_ok;
   logic         range_ok;
   logic         trig_hit;
   logic         trigger_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= trace_i.valid;
      end
   end

   always_ff @(posedge clk_i) begin
      entry_q.priv     <= trace_i.priv;
      entry_q.ctr_type <= trace_i.ctr_type;
      entry_q.pc_src   <= trace_i.pc_src;
      entry_q.pc_dst   <= trace_i.pc_dst;
   end

   //////////////////////////////////////////////////////////////////////
   // Filter
   //////////////////////////////////////////////////////////////////////

   // Reserved privilege code rejected even if its mask bit is set
   assign priv_ok  = cfg_i.priv_mask[entry_q.priv] && (entry_q.priv != PRIV_RESERVED);
   assign range_ok = !cfg_i.range_en ||
                     ((entry_q.pc_src >= cfg_i.range_lo) && (entry_q.pc_src <= cfg_i.range_hi));

   assign wr_en_o    = valid_q && cfg_i.snoop_en && priv_ok && range_ok;
   assign wr_entry_o = entry_q;

   //////////////////////////////////////////////////////////////////////
   // Trigger
   //////////////////////////////////////////////////////////////////////

   // Independent of snoop_en
   assign trig_hit = valid_q && cfg_i.trig_en && (entry_q.pc_dst == cfg_i.trig_pc);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         trigger_q <= 1'b0;
      end else begin
         trigger_q <= trig_hit;
      end
   end

   assign trigger_o = trigger_q;

   // A write always comes from an event sampled one edge earlier with a legal mode
   assert property (@(posedge clk_i) disable iff (!arst_n_i)
      wr_en_o |-> $past(trace_i.valid) && ($past(trace_i.priv) != PRIV_RESERVED))
      else $error("Buffer write for reserved privilege code");

endmodule

`default_nettype wire

/* rtl/snoop_cfg_regs.sv */
// Configuration register file, written through a single-cycle strobe and cleared by the trigger
`timescale 1ns/1ns
`default_nettype none

module snoop_cfg_regs
   import snooper_pkg::*;
(
   input  logic      clk_i,
   input  logic      arst_n_i,
   input  logic      cfg_we_i,
   input  cfg_addr_t cfg_addr_i,
   input  cfg_word_t cfg_wdata_i,
   input  logic      trigger_i,
   output cfg_t      cfg_o
);

   //////////////////////////////////////////////////////////////////////
   // Register state
   //////////////////////////////////////////////////////////////////////

   cfg_t cfg_q;
   logic ctrl_wr;

   assign ctrl_wr = cfg_we_i && (cfg_addr_i == CFG_CTRL);

   // The trigger pulse is high during the cycle after the matching edge.
   // Stored enables are dropped at the end of the pulse, unless software
   // rewrites CTRL at that very edge
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cfg_q <= '0;
      end else begin
         if (cfg_we_i) begin
            case (cfg_addr_i)
               CFG_CTRL: begin
                  cfg_q.snoop_en  <= cfg_wdata_i[CTRL_SNOOP_EN_BIT];
                  cfg_q.range_en  <= cfg_wdata_i[CTRL_RANGE_EN_BIT];
                  cfg_q.trig_en   <= cfg_wdata_i[CTRL_TRIG_EN_BIT];
                  cfg_q.priv_mask <= cfg_wdata_i[CTRL_PRIV_MASK_LSB +: 4];
               end
               CFG_RANGE_LO: begin
                  cfg_q.range_lo <= cfg_wdata_i;
               end
               CFG_RANGE_HI: begin
                  cfg_q.range_hi <= cfg_wdata_i;
               end
               CFG_TRIG_PC: begin
                  cfg_q.trig_pc <= cfg_wdata_i;
               end
               CFG_WATERMARK: begin
                  cfg_q.watermark <= cfg_wdata_i[15:0];
               end
               default: begin
                  // Writes to unmapped addresses are dropped
               end
            endcase
         end
         if (trigger_i && !ctrl_wr) begin
            cfg_q.snoop_en <= 1'b0;
            cfg_q.trig_en  <= 1'b0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Live configuration
   //////////////////////////////////////////////////////////////////////

   // Enables already read as cleared while the pulse is high, so the
   // event right after the trigger is neither recorded nor matched
   always_comb begin
      cfg_o          = cfg_q;
      cfg_o.snoop_en = cfg_q.snoop_en && !trigger_i;
      cfg_o.trig_en  = cfg_q.trig_en && !trigger_i;
   end

endmodule

`default_nettype wire

/* rtl/snooper_pkg.sv */
// Shared trace, buffer entry and configuration types, imported by every snooper module
`default_nettype none

package snooper_pkg;

   //////////////////////////////////////////////////////////////////////
   // Core event fields
   //////////////////////////////////////////////////////////////////////

   typedef logic [31:0] pc_t;

   // Code 2'b10 is reserved and never recorded
   typedef enum logic [1:0] {
      PRIV_U = 2'd0,
      PRIV_S = 2'd1,
      PRIV_M = 2'd3
   } priv_t;

   localparam logic [1:0] PRIV_RESERVED = 2'd2;

   // Branch, jump, call, return, exception, interrupt ... kept as raw code
   typedef logic [3:0] ctr_type_t;

   // One retired control-flow event as presented by the core
   typedef struct packed {
      logic      valid;
      priv_t     priv;
      ctr_type_t ctr_type;
      pc_t       pc_src;
      pc_t       pc_dst;
   } trace_t;

   // One stored buffer entry
   typedef struct packed {
      priv_t     priv;
      ctr_type_t ctr_type;
      pc_t       pc_src;
      pc_t       pc_dst;
   } trace_entry_t;

   //////////////////////////////////////////////////////////////////////
   // Configuration
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      CFG_CTRL      = 3'd0,
      CFG_RANGE_LO  = 3'd1,
      CFG_RANGE_HI  = 3'd2,
      CFG_TRIG_PC   = 3'd3,
      CFG_WATERMARK = 3'd4
   } cfg_addr_t;

   typedef logic [31:0] cfg_word_t;
   typedef logic [15:0] watermark_t;

   // CTRL register layout
   localparam int unsigned CTRL_SNOOP_EN_BIT  = 0;
   localparam int unsigned CTRL_RANGE_EN_BIT  = 1;
   localparam int unsigned CTRL_TRIG_EN_BIT   = 2;
   localparam int unsigned CTRL_PRIV_MASK_LSB = 4;

   typedef struct packed {
      logic       snoop_en;
      logic       range_en;
      logic       trig_en;
      logic [3:0] priv_mask;
      pc_t        range_lo;
      pc_t        range_hi;
      pc_t        trig_pc;
      watermark_t watermark;
   } cfg_t;

endpackage

`default_nettype wire
